// ==== rtl/axi4s_probe_cfg.svh ====
// probe widths, register map addresses and register data width
`ifndef AXI4S_PROBE_CFG_SVH
`define AXI4S_PROBE_CFG_SVH

// stream and counter widths
`define PROBE_KEEP_W 8
`define PROBE_PKT_W 50
`define PROBE_BYTE_W 56

// register port
`define PROBE_ADDR_W 5
`define PROBE_REG_W 32

// register map
`define PROBE_A_CTRL 5'h00
`define PROBE_A_PKT_LO 5'h04
`define PROBE_A_PKT_HI 5'h08
`define PROBE_A_BYTE_LO 5'h0C
`define PROBE_A_BYTE_HI 5'h10
`define PROBE_A_MONITOR 5'h14
`define PROBE_A_ACTIVITY 5'h18

`endif

// ==== rtl/axi4s_probe_pkg.sv ====
// probe mode enums, stream beat, event, count, request and flag structs, control word union
`include "axi4s_probe_cfg.svh"

package axi4s_probe_pkg;

   typedef enum logic [1:0] {
      GOOD,    // accepted packets
      OVFL,    // beats offered while tready low
      ERRORS   // packets flagged by tuser on the last beat
   } probe_mode_t;

   typedef enum logic {
      USER,
      PKT_ERROR
   } tuser_mode_t;

   // stream signals as seen on the wire
   typedef struct packed {
      logic                     tvalid;
      logic                     tready;
      logic                     tlast;
      logic                     tuser;
      logic [`PROBE_KEEP_W-1:0] tkeep;
   } stream_beat_t;

   typedef struct packed {
      logic       incr;    // beat qualifies for this mode
      logic       last;
      logic       err;     // tuser on the last beat
      logic [3:0] nbytes;
   } beat_evt_t;

   typedef struct packed {
      logic [`PROBE_PKT_W-1:0]  pkt_cnt;
      logic [`PROBE_BYTE_W-1:0] byte_cnt;
   } probe_counts_t;

   typedef struct packed {
      logic                     wr_en;
      logic                     rd_en;
      logic [`PROBE_ADDR_W-1:0] addr;
      logic [`PROBE_REG_W-1:0]  wr_data;
   } reg_req_t;

   typedef struct packed {
      logic tvalid;
      logic tready;
      logic tlast;
   } stream_flags_t;

   typedef struct packed {
      logic [`PROBE_REG_W-3:0] rsvd;
      logic                    latch;   // snapshots load on control write only
      logic                    clear;   // zero both counts
   } ctrl_fields_t;

   // same 32 bits, kept raw for readback and decoded as fields
   typedef union packed {
      logic [`PROBE_REG_W-1:0] raw;
      ctrl_fields_t            fields;
   } ctrl_word_u;

endpackage

// ==== rtl/axi4s_stream_tap.sv ====
// stream sampling, per-mode beat qualification and tkeep byte count
`timescale 1ns/100ps
`include "axi4s_probe_cfg.svh"

module axi4s_stream_tap #(
   parameter axi4s_probe_pkg::probe_mode_t MODE       = axi4s_probe_pkg::GOOD,
   parameter axi4s_probe_pkg::tuser_mode_t TUSER_MODE = axi4s_probe_pkg::USER
) (
   input  logic                           axi4s_if,
   input  logic                           reset,
   input  axi4s_probe_pkg::stream_beat_t  beat,
   output axi4s_probe_pkg::beat_evt_t     evt,
   output axi4s_probe_pkg::stream_flags_t flags
);
   import axi4s_probe_pkg::*;

   stream_beat_t beat_q;   // first sample stage
   logic         accept;
   logic         pkt_end;

   function automatic logic [3:0] count_ones(input logic [`PROBE_KEEP_W-1:0] keep);
      logic [3:0] n;
      n = '0;
      for (int i = 0; i < `PROBE_KEEP_W; i++) begin
         n = n + {3'd0, keep[i]};
      end
      return n;
   endfunction

   always_comb begin
      case (MODE)
         OVFL:    accept = beat_q.tvalid && !beat_q.tready;   // offered but refused
         default: accept = beat_q.tvalid && beat_q.tready;
      endcase
   end

   assign pkt_end = accept && beat_q.tlast;

   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         beat_q <= '0;
         evt    <= '0;
         flags  <= '0;
      end else begin
         beat_q       <= beat;
         evt.incr     <= accept;
         evt.last     <= pkt_end;
         // tuser only means error in PKT_ERROR mode
         evt.err      <= (TUSER_MODE == PKT_ERROR) && pkt_end && beat_q.tuser;
         evt.nbytes   <= accept ? count_ones(beat_q.tkeep) : 4'd0;
         flags.tvalid <= beat_q.tvalid;
         flags.tready <= beat_q.tready;
         flags.tlast  <= beat_q.tlast;
      end
   end

endmodule

// ==== rtl/axi4s_pkt_counter.sv ====
// per-packet byte accumulation with two-stage commit into packet and byte counts
`timescale 1ns/100ps
`include "axi4s_probe_cfg.svh"

module axi4s_pkt_counter #(
   parameter axi4s_probe_pkg::probe_mode_t MODE = axi4s_probe_pkg::GOOD
) (
   input  logic                           axi4s_if,
   input  logic                           reset,
   input  axi4s_probe_pkg::beat_evt_t     evt,
   input  logic                           clear_cnt,
   output axi4s_probe_pkg::probe_counts_t counts
);
   import axi4s_probe_pkg::*;

   logic [`PROBE_BYTE_W-1:0] acc_q;       // bytes of the packet in progress
   logic [`PROBE_BYTE_W-1:0] pkt_bytes;   // running total including this beat
   logic [`PROBE_BYTE_W-1:0] total_q;     // finished packet waiting to commit
   logic                     commit_q;
   logic                     drop;
   logic                     drop_q;

   assign pkt_bytes = acc_q + `PROBE_BYTE_W'(evt.nbytes);

   // ERRORS keeps only flagged packets, the other modes drop them
   assign drop = (MODE == ERRORS) ? !evt.err : evt.err;

   // stage one: close the packet and restart the accumulator
   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         acc_q    <= '0;
         commit_q <= 1'b0;
         drop_q   <= 1'b0;
      end else begin
         commit_q <= evt.last;
         drop_q   <= drop;
         if (evt.last) begin
            acc_q <= '0;
         end else if (evt.incr) begin
            acc_q <= pkt_bytes;
         end
      end
   end

   always_ff @(posedge axi4s_if) begin
      if (evt.last) begin
         total_q <= pkt_bytes;
      end
   end

   // stage two: fold the packet into the live counts
   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         counts <= '0;
      end else if (clear_cnt) begin
         counts <= '0;   // a commit landing here is lost
      end else if (commit_q && !drop_q) begin
         counts.pkt_cnt  <= counts.pkt_cnt + `PROBE_PKT_W'(1);
         counts.byte_cnt <= counts.byte_cnt + total_q;
      end
   end

endmodule

// ==== rtl/axi4s_probe_regs.sv ====
// control register, latched count snapshots, monitor and sticky activity flags, read mux
`timescale 1ns/100ps
`include "axi4s_probe_cfg.svh"

module axi4s_probe_regs (
   input  logic                           axi4s_if,
   input  logic                           reset,
   input  axi4s_probe_pkg::reg_req_t      req,
   input  axi4s_probe_pkg::probe_counts_t counts,
   input  axi4s_probe_pkg::stream_flags_t flags,
   output logic                           clear_cnt,
   output logic [`PROBE_REG_W-1:0]        rd_data
);
   import axi4s_probe_pkg::*;

   ctrl_word_u              ctrl_q;
   ctrl_word_u              wr_word;     // incoming write seen as a control word
   probe_counts_t           snap_q;
   stream_flags_t           act_q;
   logic                    ctrl_wr;
   logic                    act_rd;
   logic                    snap_load;
   logic [`PROBE_REG_W-1:0] rd_mux;

   assign wr_word.raw = req.wr_data;
   assign ctrl_wr     = req.wr_en && (req.addr == `PROBE_A_CTRL);
   assign act_rd      = req.rd_en && (req.addr == `PROBE_A_ACTIVITY);

   // free running unless latched, then only on a control write
   assign snap_load = ctrl_wr || !ctrl_q.fields.latch;

   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         ctrl_q.raw <= '0;
         clear_cnt  <= 1'b0;
      end else begin
         clear_cnt <= ctrl_wr && wr_word.fields.clear;   // single cycle pulse
         if (ctrl_wr) begin
            ctrl_q.raw <= wr_word.raw;
         end
      end
   end

   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         snap_q <= '0;
      end else if (snap_load) begin
         snap_q <= counts;
      end
   end

   // sticky flags, cleared by their own read
   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         act_q <= '0;
      end else if (act_rd) begin
         act_q <= '0;
      end else begin
         act_q <= act_q | flags;
      end
   end

   always_comb begin
      rd_mux = '0;   // unmapped reads give zero
      case (req.addr)
         `PROBE_A_CTRL:     rd_mux = ctrl_q.raw;
         `PROBE_A_PKT_LO:   rd_mux = snap_q.pkt_cnt[`PROBE_REG_W-1:0];
         `PROBE_A_PKT_HI: begin
            rd_mux[`PROBE_PKT_W-`PROBE_REG_W-1:0] =
               snap_q.pkt_cnt[`PROBE_PKT_W-1:`PROBE_REG_W];
         end
         `PROBE_A_BYTE_LO:  rd_mux = snap_q.byte_cnt[`PROBE_REG_W-1:0];
         `PROBE_A_BYTE_HI: begin
            rd_mux[`PROBE_BYTE_W-`PROBE_REG_W-1:0] =
               snap_q.byte_cnt[`PROBE_BYTE_W-1:`PROBE_REG_W];
         end
         `PROBE_A_MONITOR:  rd_mux = `PROBE_REG_W'(flags);   // live levels
         `PROBE_A_ACTIVITY: rd_mux = `PROBE_REG_W'(act_q);
         default:           rd_mux = '0;
      endcase
   end

   // read data holds until the next read strobe
   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         rd_data <= '0;
      end else if (req.rd_en) begin
         rd_data <= rd_mux;
      end
   end

endmodule

// ==== rtl/axi4s_probe_top.sv ====
// probe top level: stream tap, packet counter and register file
`timescale 1ns/100ps
`include "axi4s_probe_cfg.svh"

module axi4s_probe_top #(
   parameter axi4s_probe_pkg::probe_mode_t MODE       = axi4s_probe_pkg::GOOD,
   parameter axi4s_probe_pkg::tuser_mode_t TUSER_MODE = axi4s_probe_pkg::USER
) (
   input  logic                          axi4s_if,
   input  logic                          reset,
   input  axi4s_probe_pkg::stream_beat_t beat,
   input  axi4s_probe_pkg::reg_req_t     req,
   output logic [`PROBE_REG_W-1:0]       rd_data
);
   import axi4s_probe_pkg::*;

   beat_evt_t     evt;
   stream_flags_t flags;
   probe_counts_t counts;
   logic          clear_cnt;

   axi4s_stream_tap #(
      .MODE       (MODE),
      .TUSER_MODE (TUSER_MODE)
   ) tap0 (
      .axi4s_if (axi4s_if),
      .reset    (reset),
      .beat     (beat),
      .evt      (evt),
      .flags    (flags)
   );

   axi4s_pkt_counter #(
      .MODE (MODE)
   ) cnt0 (
      .axi4s_if  (axi4s_if),
      .reset     (reset),
      .evt       (evt),
      .clear_cnt (clear_cnt),
      .counts    (counts)
   );

   axi4s_probe_regs regs0 (
      .axi4s_if  (axi4s_if),
      .reset     (reset),
      .req       (req),
      .counts    (counts),
      .flags     (flags),
      .clear_cnt (clear_cnt),
      .rd_data   (rd_data)
   );

endmodule

// ==== sim/tb_axi4s_probe.sv ====
// testbench for the probe: stream and register stimulus, reference model, compare tasks
`timescale 1ns/100ps
`include "axi4s_probe_cfg.svh"

module tb_axi4s_probe;
   import axi4s_probe_pkg::*;

   localparam int POLL_LIMIT = 50;   // reads before a poll gives up

   logic                    axi4s_if;
   logic                    reset;
   stream_beat_t            beat;
   reg_req_t                req;
   logic [`PROBE_REG_W-1:0] rd_data;
   logic [31:0]             rng;
   probe_counts_t           model;     // expected live counts
   probe_counts_t           latched;   // counts at the latching control write
   ctrl_word_u              word;
   logic                    user;

   axi4s_probe_top #(.MODE(GOOD), .TUSER_MODE(PKT_ERROR)) dut0 (
      .axi4s_if (axi4s_if),
      .reset    (reset),
      .beat     (beat),
      .req      (req),
      .rd_data  (rd_data)
   );

   always #5 axi4s_if = ~axi4s_if;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // GOOD with PKT_ERROR, a packet flagged on its last beat is dropped from both counts
   function automatic probe_counts_t expected_counts(input probe_counts_t prev,
         input int nbeats, input logic [`PROBE_KEEP_W-1:0] last_keep, input logic tuser_last);
      probe_counts_t next;
      next = prev;
      if (!tuser_last) begin
         next.pkt_cnt  = prev.pkt_cnt + `PROBE_PKT_W'(1);
         next.byte_cnt = prev.byte_cnt +   // all lanes valid before the last beat
            `PROBE_BYTE_W'(`PROBE_KEEP_W * (nbeats - 1) + $countones(last_keep));
      end
      return next;
   endfunction

   task automatic stop_with_failure();
      $display("Checks failed");
      $fatal(1, "stopped at the first failing check");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      stop_with_failure();
   endtask

   task automatic drive_beat(input logic valid, input logic ready, input logic last,
                             input logic tuser, input logic [`PROBE_KEEP_W-1:0] keep);
      beat.tvalid = valid;
      beat.tready = ready;
      beat.tlast  = last;
      beat.tuser  = tuser;
      beat.tkeep  = keep;
      @(posedge axi4s_if);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      beat = '0;
      repeat (n) begin
         @(posedge axi4s_if);
         #1;
      end
   endtask

   task automatic reg_write(input logic [`PROBE_ADDR_W-1:0] addr,
                            input logic [`PROBE_REG_W-1:0] data);
      req.wr_en   = 1'b1;
      req.addr    = addr;
      req.wr_data = data;
      @(posedge axi4s_if);
      #1;
      req.wr_en = 1'b0;
   endtask

   task automatic reg_read(input logic [`PROBE_ADDR_W-1:0] addr,
                           output logic [`PROBE_REG_W-1:0] data);
      req.rd_en = 1'b1;
      req.addr  = addr;
      @(posedge axi4s_if);
      #1;
      req.rd_en = 1'b0;
      data      = rd_data;   // registered on the strobe edge
   endtask

   task automatic random_packet(input logic tuser_last);
      int                       nbeats;
      logic [`PROBE_KEEP_W-1:0] last_keep;
      logic [`PROBE_KEEP_W-1:0] keep;
      logic                     last;
      rng       = xorshift32(rng);
      nbeats    = 1 + int'(rng % 32'd6);
      rng       = xorshift32(rng);
      last_keep = rng[`PROBE_KEEP_W-1:0];
      for (int i = 0; i < nbeats; i++) begin
         last = (i == nbeats - 1);
         keep = last ? last_keep : {`PROBE_KEEP_W{1'b1}};
         rng  = xorshift32(rng);
         for (int s = 0; s < int'(rng[1:0]); s++) begin
            drive_beat(1'b1, 1'b0, last, tuser_last && last, keep);   // stalled
         end
         drive_beat(1'b1, 1'b1, last, tuser_last && last, keep);
      end
      model = expected_counts(model, nbeats, last_keep, tuser_last);
   endtask

   // relatch rewrites the control word before each read so latched snapshots reload
   task automatic wait_pkt_count(input logic [`PROBE_PKT_W-1:0] exp_pkts, input bit relatch);
      logic [`PROBE_REG_W-1:0] rd;
      bit                      seen;
      seen = 1'b0;
      for (int n = 0; n < POLL_LIMIT && !seen; n++) begin
         if (relatch) reg_write(`PROBE_A_CTRL, 32'h2);
         reg_read(`PROBE_A_PKT_LO, rd);
         seen = (rd == exp_pkts[31:0]);
      end
      if (!seen) begin
         $display("timeout: packet count did not reach %0d within %0d reads",
                  exp_pkts, POLL_LIMIT);
         stop_with_failure();
      end
   endtask

   task automatic check_counts(input probe_counts_t exp);
      logic [`PROBE_REG_W-1:0] rd;
      reg_read(`PROBE_A_PKT_LO, rd);
      if (rd !== exp.pkt_cnt[31:0]) report_mismatch("pkt_cnt lo", exp.pkt_cnt[31:0], rd);
      reg_read(`PROBE_A_PKT_HI, rd);
      if (rd !== 32'(exp.pkt_cnt >> 32)) report_mismatch("pkt_cnt hi", 32'(exp.pkt_cnt >> 32), rd);
      reg_read(`PROBE_A_BYTE_LO, rd);
      if (rd !== exp.byte_cnt[31:0]) report_mismatch("byte_cnt lo", exp.byte_cnt[31:0], rd);
      reg_read(`PROBE_A_BYTE_HI, rd);
      if (rd !== 32'(exp.byte_cnt >> 32))
         report_mismatch("byte_cnt hi", 32'(exp.byte_cnt >> 32), rd);
   endtask

   task automatic check_flags(input logic [`PROBE_ADDR_W-1:0] addr, input string name,
                              input stream_flags_t exp);
      logic [`PROBE_REG_W-1:0] rd;
      reg_read(addr, rd);
      if (rd !== {29'd0, exp}) report_mismatch(name, {29'd0, exp}, rd);
   endtask

   task automatic check_word(input ctrl_word_u exp);
      logic [`PROBE_REG_W-1:0] rd;
      reg_read(`PROBE_A_CTRL, rd);
      if (rd !== exp.raw) report_mismatch("ctrl", exp.raw, rd);
   endtask

   initial begin
      axi4s_if = 1'b0;
      reset    = 1'b1;
      beat     = '0;
      req      = '0;
      rng      = 32'he895a66e;
      model    = '0;
      repeat (4) @(posedge axi4s_if);
      #1 reset = 1'b0;

      repeat (10) random_packet(1'b0);   // clean packets with stalls
      idle_cycles(2);
      wait_pkt_count(model.pkt_cnt, 1'b0);
      check_counts(model);

      for (int i = 0; i < 8; i++) begin   // error packets mixed in, last one clean
         rng  = xorshift32(rng);
         user = (i == 0) || (i < 7 && rng[0]);
         random_packet(user);
      end
      idle_cycles(2);
      wait_pkt_count(model.pkt_cnt, 1'b0);
      check_counts(model);

      word.raw = 32'h00a5_0001;   // clear with some reserved bits for readback
      reg_write(`PROBE_A_CTRL, word.raw);
      model = '0;
      wait_pkt_count(model.pkt_cnt, 1'b0);
      check_counts(model);
      check_word(word);
      repeat (4) random_packet(1'b0);
      idle_cycles(2);
      wait_pkt_count(model.pkt_cnt, 1'b0);
      check_counts(model);

      latched = model;
      reg_write(`PROBE_A_CTRL, 32'h2);
      repeat (3) random_packet(1'b0);
      idle_cycles(2);
      repeat (3) check_counts(latched);   // live counts moved, snapshot must not
      wait_pkt_count(model.pkt_cnt, 1'b1);
      check_counts(model);
      word.raw = 32'h0;
      reg_write(`PROBE_A_CTRL, word.raw);
      check_word(word);

      check_flags(`PROBE_A_ACTIVITY, "activity", 3'b111);
      repeat (3) drive_beat(1'b1, 1'b0, 1'b1, 1'b0, {`PROBE_KEEP_W{1'b1}});
      check_flags(`PROBE_A_MONITOR, "monitor", 3'b101);   // beat still held here
      idle_cycles(4);
      check_flags(`PROBE_A_ACTIVITY, "activity", 3'b101);
      check_flags(`PROBE_A_ACTIVITY, "activity", 3'b000);
      check_counts(model);

      $display("All checks passed");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/axi4s_probe_pkg.sv
rtl/axi4s_stream_tap.sv
rtl/axi4s_pkt_counter.sv
rtl/axi4s_probe_regs.sv
rtl/axi4s_probe_top.sv
sim/tb_axi4s_probe.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_axi4s_probe
FILELIST  = build.f
OBJDIR    = obj_dir
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the exit status is that of the search for the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
